//--- Bender.yml
package:
  name: conv_quad

sources:
  - files:
      - verilog/conv_data_pkg.sv
      - verilog/conv_ctrl_pkg.sv
      - verilog/tap_store.sv
      - verilog/pixel_window.sv
      - verilog/weight_table.sv
      - verilog/conv_mac.sv
      - verilog/conv_quad_top.sv
  - target: simulation
    files:
      - sim/conv_mac_properties.sv
      - sim/conv_quad_tb.sv

//--- conv_quad.f
verilog/conv_data_pkg.sv
verilog/conv_ctrl_pkg.sv
verilog/tap_store.sv
verilog/pixel_window.sv
verilog/weight_table.sv
verilog/conv_mac.sv
verilog/conv_quad_top.sv
sim/conv_mac_properties.sv
sim/conv_quad_tb.sv

//--- sim/conv_mac_properties.sv
`timescale 1ns/1ps

module conv_mac_properties #(
    parameter int NUM_KERNELS = 4
) (
    input logic                       clk_core,
    input logic                       rst,
    input logic                       kernel_rd,
    input conv_ctrl_pkg::kernel_idx_t kernel_sel,
    input logic                       busy,
    input logic                       result_valid,
    input logic                       job_done
);

    ////////////////////
    // Sequencer rules
    ////////////////////

    // Results only leave the pipe inside a job
    property result_inside_job;
        @(posedge clk_core) disable iff (rst)
            result_valid |-> busy;
    endproperty

    // Last kernel carries the done flag
    property done_with_result;
        @(posedge clk_core) disable iff (rst)
            job_done |-> result_valid;
    endproperty

    property kernel_in_range;
        @(posedge clk_core) disable iff (rst)
            kernel_rd |-> (int'(kernel_sel) < NUM_KERNELS);
    endproperty

    result_inside_job_a : assert property (result_inside_job)
        else $error("result_valid high while busy is low");

    done_with_result_a : assert property (done_with_result)
        else $error("job_done high without result_valid");

    kernel_in_range_a : assert property (kernel_in_range)
        else $error("kernel_sel %0d read beyond the last kernel", kernel_sel);

endmodule

bind conv_mac conv_mac_properties #(
    .NUM_KERNELS (NUM_KERNELS)
) conv_mac_properties_inst (
    .clk_core     (clk_core),
    .rst          (rst),
    .kernel_rd    (kernel_rd),
    .kernel_sel   (kernel_sel),
    .busy         (busy),
    .result_valid (result_valid),
    .job_done     (job_done)
);

//--- sim/conv_quad_tb.sv
`timescale 1ns/1ps

module conv_quad_tb;

    localparam int NUM_KERNELS = 4;
    localparam int K_TAPS      = conv_data_pkg::K_TAPS;
    localparam int PIX_MSB     = conv_data_pkg::PIXEL_WIDTH - 1;

    // Loads of 45 writes plus a handful of short jobs stay near 400 cycles
    localparam int TEST_CYCLES    = 400;
    localparam int TIMEOUT_CYCLES = 5 * TEST_CYCLES;
    localparam int JOB_LIMIT      = 20;

    // Disturbance applied while a job runs
    localparam int MODE_PLAIN   = 0;
    localparam int MODE_WRITES  = 1;
    localparam int MODE_RESTART = 2;

    logic                       clk_core;
    logic                       rst;
    logic                       pixel_valid;
    conv_data_pkg::pixel_t      pixel_data;
    logic                       relu_en;
    logic                       weight_valid;
    conv_data_pkg::weight_t     weight_data;
    logic                       job_start;
    logic                       busy;
    logic                       result_valid;
    conv_data_pkg::result_t     result_data;
    conv_ctrl_pkg::kernel_idx_t result_kernel;
    logic                       job_done;

    // Reference copy of what the quad should hold
    conv_data_pkg::pixel_t  model_pixels [K_TAPS];
    conv_data_pkg::weight_t model_weights [NUM_KERNELS * K_TAPS];
    int                     pixel_ptr = 0;
    int                     weight_ptr = 0;
    logic [31:0]            lfsr_state = 32'h36d8;
    int                     cycle_count;

    conv_quad_top #(
        .NUM_KERNELS (NUM_KERNELS)
    ) conv_quad_top_inst (
        .clk_core      (clk_core),
        .rst           (rst),
        .pixel_valid   (pixel_valid),
        .pixel_data    (pixel_data),
        .relu_en       (relu_en),
        .weight_valid  (weight_valid),
        .weight_data   (weight_data),
        .job_start     (job_start),
        .busy          (busy),
        .result_valid  (result_valid),
        .result_data   (result_data),
        .result_kernel (result_kernel),
        .job_done      (job_done)
    );

    initial begin
        clk_core = 1'b0;
        forever #50 clk_core = ~clk_core;
    end

    ////////////////////
    // Reporting
    ////////////////////
    task automatic report_mismatch(input string name, input longint expected,
                                   input longint actual);
        $display("[ERROR] %0t: %s expected %0d, got %0d", $time, name, expected, actual);
        $display("ERRORS FOUND");
        $fatal(1, "Stopped at first mismatch");
    endtask

    task automatic report_problem(input string what);
        $display("%0t: %s", $time, what);
        $display("ERRORS FOUND");
        $fatal(1, "Stopped at first problem");
    endtask

    ////////////////////
    // Stimulus source
    ////////////////////

    // Fibonacci LFSR, taps 32 22 2 1
    function automatic logic next_bit();
        logic fb;
        fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] random_word(input int nbits);
        logic [31:0] word;
        word = '0;
        for (int i = 0; i < nbits; i++) begin
            word = {word[30:0], next_bit()};
        end
        return word;
    endfunction

    // Dot product of the window with one kernel
    function automatic longint expected_sum(input int k);
        longint acc;
        acc = 0;
        for (int t = 0; t < K_TAPS; t++) begin
            acc += longint'(model_pixels[t]) * longint'(model_weights[k * K_TAPS + t]);
        end
        return acc;
    endfunction

    ////////////////////
    // Load tasks
    ////////////////////
    task automatic write_pixel(input conv_data_pkg::pixel_t pix, input logic relu);
        @(posedge clk_core);
        pixel_valid <= 1'b1;
        pixel_data  <= pix;
        relu_en     <= relu;
        model_pixels[pixel_ptr] = (relu && pix < 0) ? '0 : pix;
        pixel_ptr = (pixel_ptr + 1) % K_TAPS;
    endtask

    task automatic load_window(input logic relu, input bit force_negative);
        conv_data_pkg::pixel_t pix;
        for (int t = 0; t < K_TAPS; t++) begin
            pix = conv_data_pkg::pixel_t'(random_word(16));
            // Every other tap made negative
            if (force_negative && (t % 2 == 0)) begin
                pix[PIX_MSB] = 1'b1;
            end
            write_pixel(pix, relu);
        end
        @(posedge clk_core);
        pixel_valid <= 1'b0;
    endtask

    task automatic load_kernels();
        conv_data_pkg::weight_t w;
        for (int i = 0; i < NUM_KERNELS * K_TAPS; i++) begin
            w = conv_data_pkg::weight_t'(random_word(16));
            @(posedge clk_core);
            weight_valid <= 1'b1;
            weight_data  <= w;
            model_weights[weight_ptr] = w;
            weight_ptr = (weight_ptr + 1) % (NUM_KERNELS * K_TAPS);
        end
        @(posedge clk_core);
        weight_valid <= 1'b0;
    endtask

    ////////////////////
    // Job and idle checks
    ////////////////////
    task automatic check_quiet(input int cycles);
        repeat (cycles) begin
            @(posedge clk_core);
            pixel_valid  <= 1'b0;
            weight_valid <= 1'b0;
            job_start    <= 1'b0;
            @(negedge clk_core);
            assert (busy === 1'b0) else report_mismatch("busy", 0, busy);
            assert (result_valid === 1'b0) else report_mismatch("result_valid", 0, result_valid);
            assert (job_done === 1'b0) else report_mismatch("job_done", 0, job_done);
        end
    endtask

    task automatic run_job(input int mode);
        int  cyc;
        int  next_k;
        bit  finished;
        cyc      = 0;
        next_k   = 0;
        finished = 0;
        @(posedge clk_core);
        job_start    <= 1'b1;
        pixel_valid  <= 1'b0;
        weight_valid <= 1'b0;
        @(negedge clk_core);
        assert (busy === 1'b0) else report_mismatch("busy", 0, busy);
        while (!finished) begin
            @(posedge clk_core);
            cyc++;
            // Restart attempts mid job and in the job_done cycle
            job_start <= (mode == MODE_RESTART) && (cyc == 3 || cyc == 3 + NUM_KERNELS);
            if (mode == MODE_WRITES) begin
                pixel_valid  <= 1'b1;
                pixel_data   <= conv_data_pkg::pixel_t'(random_word(16));
                relu_en      <= next_bit();
                weight_valid <= 1'b1;
                weight_data  <= conv_data_pkg::weight_t'(random_word(16));
            end
            @(negedge clk_core);
            assert (busy === 1'b1) else report_mismatch("busy", 1, busy);
            if (result_valid === 1'b1) begin
                assert (next_k < NUM_KERNELS)
                    else report_problem("More results than kernels in one job");
                assert (cyc == 4 + next_k) else report_mismatch("result cycle", 4 + next_k, cyc);
                assert (result_kernel === conv_ctrl_pkg::kernel_idx_t'(next_k))
                    else report_mismatch("result_kernel", next_k, result_kernel);
                assert (longint'(result_data) == expected_sum(next_k))
                    else report_mismatch("result_data", expected_sum(next_k), result_data);
                assert (job_done === logic'(next_k == NUM_KERNELS - 1))
                    else report_mismatch("job_done", next_k == NUM_KERNELS - 1, job_done);
                finished = (next_k == NUM_KERNELS - 1);
                next_k++;
            end else begin
                assert (job_done === 1'b0) else report_problem("job_done came without a result");
            end
            assert (finished || cyc < JOB_LIMIT)
                else report_problem("Job did not finish within the cycle limit");
        end
    endtask

    ////////////////////
    // Directed tests
    ////////////////////
    task automatic check_reset_state();
        check_quiet(10);
    endtask

    task automatic basic_job();
        load_window(1'b0, 1'b0);
        load_kernels();
        run_job(MODE_PLAIN);
        check_quiet(3);
    endtask

    task automatic relu_job();
        load_window(1'b1, 1'b1);
        run_job(MODE_PLAIN);
        check_quiet(3);
    endtask

    // Stored values must survive writes during a job
    task automatic busy_writes_job();
        run_job(MODE_WRITES);
        check_quiet(2);
        run_job(MODE_PLAIN);
        check_quiet(3);
    endtask

    task automatic busy_start_job();
        load_window(1'b0, 1'b0);
        load_kernels();
        run_job(MODE_RESTART);
        run_job(MODE_PLAIN);
        check_quiet(6);
    endtask

    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk_core);
            cycle_count++;
        end
        $display("Simulation ran past %0d cycles without finishing", TIMEOUT_CYCLES);
        $display("ERRORS FOUND");
        $fatal(1, "Timeout");
    end

    initial begin
        rst          <= 1'b1;
        pixel_valid  <= 1'b0;
        pixel_data   <= '0;
        relu_en      <= 1'b0;
        weight_valid <= 1'b0;
        weight_data  <= '0;
        job_start    <= 1'b0;
        repeat (16) @(posedge clk_core);
        rst <= 1'b0;

        check_reset_state();
        basic_job();
        relu_job();
        busy_writes_job();
        busy_start_job();

        $display("NO ERRORS");
        $finish;
    end

endmodule

//--- verilog/conv_ctrl_pkg.sv
package conv_ctrl_pkg;

    ////////////////////
    // Job limits
    ////////////////////

    // Largest kernel count one quad can hold
    localparam int MAX_KERNELS = 16;

    typedef logic [$clog2(MAX_KERNELS)-1:0] kernel_idx_t;

    // Issue to result: weight read, product, adder tree
    localparam int MAC_LATENCY = 3;

    ////////////////////
    // Sequencer
    ////////////////////
    typedef enum logic [1:0] {
        SWEEP_IDLE,
        SWEEP_ISSUE,
        SWEEP_DRAIN
    } sweep_state_t;

endpackage

//--- verilog/conv_data_pkg.sv
package conv_data_pkg;

    ////////////////////
    // Sample widths
    ////////////////////
    localparam int PIXEL_WIDTH  = 16;
    localparam int WEIGHT_WIDTH = 16;

    // Taps in one 3x3 window
    localparam int K_TAPS = 9;

    // Full precision of one multiply
    localparam int PRODUCT_WIDTH = PIXEL_WIDTH + WEIGHT_WIDTH;

    // Guard bits so nine products never overflow the sum
    localparam int RESULT_WIDTH = PRODUCT_WIDTH + $clog2(K_TAPS);

    ////////////////////
    // Datapath types
    ////////////////////
    typedef logic signed [PIXEL_WIDTH-1:0]   pixel_t;
    typedef logic signed [WEIGHT_WIDTH-1:0]  weight_t;
    typedef logic signed [PRODUCT_WIDTH-1:0] product_t;
    typedef logic signed [RESULT_WIDTH-1:0]  result_t;

endpackage

//--- verilog/conv_mac.sv
`timescale 1ns/1ps

module conv_mac #(
    parameter int NUM_KERNELS = 4
) (
    input  logic                        clk_core,
    input  logic                        rst,
    input  logic                        job_start,
    input  conv_data_pkg::pixel_t       pixel_taps [conv_data_pkg::K_TAPS],
    input  conv_data_pkg::weight_t      kernel_weights [conv_data_pkg::K_TAPS],
    output logic                        kernel_rd,
    output conv_ctrl_pkg::kernel_idx_t  kernel_sel,
    output logic                        busy,
    output logic                        result_valid,
    output conv_data_pkg::result_t      result_data,
    output conv_ctrl_pkg::kernel_idx_t  result_kernel,
    output logic                        job_done
);

    localparam int K_TAPS = conv_data_pkg::K_TAPS;
    localparam int LAT    = conv_ctrl_pkg::MAC_LATENCY;

    // Sideband stage holding the products
    localparam int STAGE_PROD = 1;

    conv_ctrl_pkg::sweep_state_t state;
    conv_ctrl_pkg::kernel_idx_t  issue_idx;
    logic                        issue_last;

    logic [LAT-1:0]              valid_q;
    logic [LAT-1:0]              last_q;
    conv_ctrl_pkg::kernel_idx_t  idx_q [LAT];

    conv_data_pkg::product_t     prod_q [K_TAPS];
    conv_data_pkg::result_t      tree_sum;
    conv_data_pkg::result_t      sum_q;

    ////////////////////
    // Job sequencer
    ////////////////////
    assign kernel_rd  = (state == conv_ctrl_pkg::SWEEP_ISSUE);
    assign kernel_sel = issue_idx;
    assign busy       = (state != conv_ctrl_pkg::SWEEP_IDLE);
    assign issue_last = kernel_rd &&
                        (issue_idx == conv_ctrl_pkg::kernel_idx_t'(NUM_KERNELS - 1));

    always_ff @(posedge clk_core) begin
        if (rst) begin
            state     <= conv_ctrl_pkg::SWEEP_IDLE;
            issue_idx <= '0;
        end else begin
            case (state)
                conv_ctrl_pkg::SWEEP_IDLE: begin
                    issue_idx <= '0;
                    if (job_start) begin
                        state <= conv_ctrl_pkg::SWEEP_ISSUE;
                    end
                end
                conv_ctrl_pkg::SWEEP_ISSUE: begin
                    issue_idx <= issue_idx + 1'b1;
                    if (issue_last) begin
                        state <= conv_ctrl_pkg::SWEEP_DRAIN;
                    end
                end
                // Wait for the last kernel to leave the tree
                conv_ctrl_pkg::SWEEP_DRAIN: begin
                    if (job_done) begin
                        state <= conv_ctrl_pkg::SWEEP_IDLE;
                    end
                end
                default: begin
                    state <= conv_ctrl_pkg::SWEEP_IDLE;
                end
            endcase
        end
    end

    ////////////////////
    // Sideband pipe
    ////////////////////
    always_ff @(posedge clk_core) begin
        if (rst) begin
            valid_q <= '0;
            last_q  <= '0;
        end else begin
            valid_q <= {valid_q[LAT-2:0], kernel_rd};
            last_q  <= {last_q[LAT-2:0], issue_last};
        end
    end

    always_ff @(posedge clk_core) begin
        idx_q[0] <= kernel_sel;
        for (int s = 1; s < LAT; s++) begin
            idx_q[s] <= idx_q[s-1];
        end
    end

    ////////////////////
    // Multiply and sum
    ////////////////////

    // Weights of the issued kernel are on the table port now
    always_ff @(posedge clk_core) begin
        if (valid_q[0]) begin
            for (int t = 0; t < K_TAPS; t++) begin
                prod_q[t] <= pixel_taps[t] * kernel_weights[t];
            end
        end
    end

    always_comb begin
        tree_sum = '0;
        for (int t = 0; t < K_TAPS; t++) begin
            tree_sum = tree_sum + conv_data_pkg::result_t'(prod_q[t]);
        end
    end

    always_ff @(posedge clk_core) begin
        if (valid_q[STAGE_PROD]) begin
            sum_q <= tree_sum;
        end
    end

    assign result_valid  = valid_q[LAT-1];
    assign result_kernel = idx_q[LAT-1];
    assign result_data   = sum_q;
    assign job_done      = last_q[LAT-1];

endmodule

//--- verilog/conv_quad_top.sv
`timescale 1ns/1ps

module conv_quad_top #(
    parameter int NUM_KERNELS = 4
) (
    input  logic                        clk_core,
    input  logic                        rst,

    // Window load
    input  logic                        pixel_valid,
    input  conv_data_pkg::pixel_t       pixel_data,
    input  logic                        relu_en,

    // Kernel load
    input  logic                        weight_valid,
    input  conv_data_pkg::weight_t      weight_data,

    // Job control and results
    input  logic                        job_start,
    output logic                        busy,
    output logic                        result_valid,
    output conv_data_pkg::result_t      result_data,
    output conv_ctrl_pkg::kernel_idx_t  result_kernel,
    output logic                        job_done
);

    conv_data_pkg::pixel_t       pixel_taps [conv_data_pkg::K_TAPS];
    conv_data_pkg::weight_t      kernel_weights [conv_data_pkg::K_TAPS];
    logic                        kernel_rd;
    conv_ctrl_pkg::kernel_idx_t  kernel_sel;

    ////////////////////
    // Stores
    ////////////////////

    // Both stores hold their contents while busy
    pixel_window pixel_window_inst (
        .clk_core    (clk_core),
        .rst         (rst),
        .pixel_valid (pixel_valid),
        .pixel_data  (pixel_data),
        .relu_en     (relu_en),
        .hold        (busy),
        .taps        (pixel_taps)
    );

    weight_table #(
        .NUM_KERNELS (NUM_KERNELS)
    ) weight_table_inst (
        .clk_core       (clk_core),
        .rst            (rst),
        .weight_valid   (weight_valid),
        .weight_data    (weight_data),
        .hold           (busy),
        .kernel_rd      (kernel_rd),
        .kernel_sel     (kernel_sel),
        .kernel_weights (kernel_weights)
    );

    ////////////////////
    // MAC engine
    ////////////////////
    conv_mac #(
        .NUM_KERNELS (NUM_KERNELS)
    ) conv_mac_inst (
        .clk_core       (clk_core),
        .rst            (rst),
        .job_start      (job_start),
        .pixel_taps     (pixel_taps),
        .kernel_weights (kernel_weights),
        .kernel_rd      (kernel_rd),
        .kernel_sel     (kernel_sel),
        .busy           (busy),
        .result_valid   (result_valid),
        .result_data    (result_data),
        .result_kernel  (result_kernel),
        .job_done       (job_done)
    );

endmodule

//--- verilog/pixel_window.sv
`timescale 1ns/1ps

module pixel_window (
    input  logic                  clk_core,
    input  logic                  rst,
    input  logic                  pixel_valid,
    input  conv_data_pkg::pixel_t pixel_data,
    input  logic                  relu_en,
    input  logic                  hold,
    output conv_data_pkg::pixel_t taps [conv_data_pkg::K_TAPS]
);

    logic                  wr_en;
    conv_data_pkg::pixel_t wr_pixel;
    logic                  is_negative;

    ////////////////////
    // Write side
    ////////////////////

    // Window is frozen while a job runs
    assign wr_en = pixel_valid && !hold;

    assign is_negative = pixel_data[conv_data_pkg::PIXEL_WIDTH-1];

    // ReLU clamps negatives at write time
    assign wr_pixel = (relu_en && is_negative) ? '0 : pixel_data;

    tap_store #(
        .elem_t (conv_data_pkg::pixel_t),
        .DEPTH  (conv_data_pkg::K_TAPS)
    ) tap_store_inst (
        .clk_core (clk_core),
        .rst      (rst),
        .wr_en    (wr_en),
        .wr_data  (wr_pixel),
        .taps     (taps)
    );

endmodule

//--- verilog/tap_store.sv
`timescale 1ns/1ps

module tap_store #(
    parameter type elem_t = logic [15:0],
    parameter int  DEPTH  = 9
) (
    input  logic  clk_core,
    input  logic  rst,
    input  logic  wr_en,
    input  elem_t wr_data,
    output elem_t taps [DEPTH]
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    logic [PTR_W-1:0] wr_ptr;

    // Write pointer, wraps after the last entry
    always_ff @(posedge clk_core) begin
        if (rst) begin
            wr_ptr <= '0;
        end else if (wr_en) begin
            if (wr_ptr == PTR_W'(DEPTH - 1)) begin
                wr_ptr <= '0;
            end else begin
                wr_ptr <= wr_ptr + 1'b1;
            end
        end
    end

    // Storage, all entries visible at once
    always_ff @(posedge clk_core) begin
        if (wr_en) begin
            taps[wr_ptr] <= wr_data;
        end
    end

endmodule

//--- verilog/weight_table.sv
`timescale 1ns/1ps

module weight_table #(
    parameter int NUM_KERNELS = 4
) (
    input  logic                        clk_core,
    input  logic                        rst,
    input  logic                        weight_valid,
    input  conv_data_pkg::weight_t      weight_data,
    input  logic                        hold,
    input  logic                        kernel_rd,
    input  conv_ctrl_pkg::kernel_idx_t  kernel_sel,
    output conv_data_pkg::weight_t      kernel_weights [conv_data_pkg::K_TAPS]
);

    localparam int K_TAPS = conv_data_pkg::K_TAPS;
    localparam int DEPTH  = NUM_KERNELS * K_TAPS;

    logic                   wr_en;
    conv_data_pkg::weight_t all_weights [DEPTH];

    ////////////////////
    // Load side
    ////////////////////

    // Kernel k occupies entries k*9 to k*9+8
    assign wr_en = weight_valid && !hold;

    tap_store #(
        .elem_t (conv_data_pkg::weight_t),
        .DEPTH  (DEPTH)
    ) tap_store_inst (
        .clk_core (clk_core),
        .rst      (rst),
        .wr_en    (wr_en),
        .wr_data  (weight_data),
        .taps     (all_weights)
    );

    ////////////////////
    // Read side
    ////////////////////

    // One kernel per read, out the following cycle
    always_ff @(posedge clk_core) begin
        if (kernel_rd) begin
            for (int t = 0; t < K_TAPS; t++) begin
                kernel_weights[t] <= all_weights[int'(kernel_sel) * K_TAPS + t];
            end
        end
    end

endmodule
